//--- mini16_fabric.f
verilog/mini16_fabric_pkg.sv
verilog/shared_ram.sv
verilog/bus_decode.sv
verilog/io_reg_file.sv
verilog/read_select.sv
verilog/mini16_fabric.sv
testbench/mini16_fabric_assertions.sv
testbench/tb_mini16_fabric.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_mini16_fabric -f mini16_fabric.f -o sim_mini16_fabric

./obj_dir/sim_mini16_fabric 2>&1 | tee sim.log

if grep -q "Result: PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

//--- testbench/fabric_cases.txt
// op addr data expected, all hex; op 0 master write, 1 harvester write,
// 2 read check, 3 led check, 4 pe_soft_reset check, f end of cases
3 00000 00000000 00000000
4 00000 00000000 00000000
// Data memory, overwrite one address and keep the other
0 00010 11111111 00000000
0 00011 22222222 00000000
2 0010 00000000 11111111
0 00010 33333333 00000000
2 0011 00000000 22222222
2 0010 00000000 33333333
// I/O registers 1 and 0
0 01001 1234a5c3 00000000
3 00000 00000000 0000a5c3
0 01000 00000001 00000000
4 00000 00000000 00000001
2 0801 00000000 1234a5c3
2 0800 00000000 00000001
// Harvester into s2m, then a VRAM write to the same offset
1 00020 cafe0020 00000000
2 1020 00000000 cafe0020
2 1820 00000000 cafe0020
1 20020 dead0020 00000000
2 1020 00000000 cafe0020
// PE and broadcast banks leave local targets alone
0 02010 44444444 00000000
0 3f010 55555555 00000000
0 02001 66666666 00000000
0 3f000 00000000 00000000
3 00000 00000000 0000a5c3
4 00000 00000000 00000001
// Back-to-back reads over all banks
2 0010 00000000 33333333
2 0801 00000000 1234a5c3
2 1020 00000000 cafe0020
2 0011 00000000 22222222
2 1820 00000000 cafe0020
f 00000 00000000 00000000

//--- testbench/mini16_fabric_assertions.sv
/* Bound into bus_decode. Covers local strobes against the bank on pe_wr, strobe state
   in reset and the one-cycle delay of the PE write bus. */
`timescale 1ns/1ps
`default_nettype none

module mini16_fabric_assertions (
  input wire                                clk,
  input wire                                rst,
  input wire mini16_fabric_pkg::master_wr_t master_wr,
  input wire mini16_fabric_pkg::ram_wr_t    mem_d_wr,
  input wire mini16_fabric_pkg::ram_wr_t    io_wr,
  input wire mini16_fabric_pkg::ram_wr_t    s2m_wr,
  input wire mini16_fabric_pkg::master_wr_t pe_wr
);

  logic [mini16_fabric_pkg::CORE_BITS-1:0] pe_bank;

  assign pe_bank = pe_wr.addr[mini16_fabric_pkg::DEPTH_B_M_W +: mini16_fabric_pkg::CORE_BITS];

  // Each local strobe comes with a pe_wr write to its own bank, so one target at most
  strobe_bank_match: assert property (@(posedge clk)
    (!mem_d_wr.we || (pe_wr.we && pe_bank == mini16_fabric_pkg::W_BANK_MEM_D)) &&
    (!io_wr.we || (pe_wr.we && pe_bank == mini16_fabric_pkg::W_BANK_IO_REG)))
    else $error("A local write strobe does not match the bank of the write on pe_wr");

  // Strobes clear on the first edge of reset
  reset_strobes_low: assert property (@(posedge clk)
    rst |=> !(mem_d_wr.we || io_wr.we || s2m_wr.we || pe_wr.we))
    else $error("A write strobe is high during reset");

  pe_wr_delay: assert property (@(posedge clk) !rst |=> pe_wr == $past(master_wr))
    else $error("pe_wr differs from master_wr of the previous cycle");

endmodule

bind bus_decode mini16_fabric_assertions u_bus_decode_assertions (
  .clk       (clk),
  .rst       (rst),
  .master_wr (master_wr),
  .mem_d_wr  (mem_d_wr),
  .io_wr     (io_wr),
  .s2m_wr    (s2m_wr),
  .pe_wr     (pe_wr)
);

`default_nettype wire

//--- testbench/tb_mini16_fabric.sv
/* Cases come from testbench/fabric_cases.txt, so the run starts in the project root.
   Reads are checked two cycles after their address and pe_wr one cycle after master_wr. */
`timescale 1ns/1ps
`default_nettype none

module tb_mini16_fabric;

  localparam int          MAX_CASES     = 64;
  localparam logic [31:0] OP_MASTER_WR  = 32'h0;
  localparam logic [31:0] OP_HARVEST_WR = 32'h1;
  localparam logic [31:0] OP_READ       = 32'h2;
  localparam logic [31:0] OP_LED        = 32'h3;
  localparam logic [31:0] OP_SOFT_RESET = 32'h4;
  localparam logic [31:0] OP_END        = 32'hf;

  logic                           clk = 1'b0;
  logic                           rst;
  mini16_fabric_pkg::master_wr_t  master_wr;
  mini16_fabric_pkg::r_addr_t     master_raddr;
  mini16_fabric_pkg::harvest_wr_t harvest_wr;
  mini16_fabric_pkg::data_t       master_rdata;
  mini16_fabric_pkg::master_wr_t  pe_wr;
  mini16_fabric_pkg::led_t        led;
  logic                           pe_soft_reset;

  logic [31:0] case_mem [0:4*MAX_CASES-1];
  int          n_cases;
  int          cycle_limit;
  int          cycle_count = 0;

  // Expected read results delayed to the read latency
  logic                       rd_issue;
  mini16_fabric_pkg::data_t   rd_expect;
  logic                       rd_v1;
  logic                       rd_v2;
  mini16_fabric_pkg::data_t   rd_e1;
  mini16_fabric_pkg::data_t   rd_e2;
  mini16_fabric_pkg::r_addr_t rd_a1;
  mini16_fabric_pkg::r_addr_t rd_a2;

  // Previous cycle carried no master write
  logic                       pe_idle;

  mini16_fabric u_mini16_fabric (
    .clk           (clk),
    .rst           (rst),
    .master_wr     (master_wr),
    .master_raddr  (master_raddr),
    .harvest_wr    (harvest_wr),
    .master_rdata  (master_rdata),
    .pe_wr         (pe_wr),
    .led           (led),
    .pe_soft_reset (pe_soft_reset)
  );

  always #4 clk = ~clk;

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string what, input string expected, input string actual);
    abort_run($sformatf("Fail at time %0t: %s expected %s, got %s", $time, what, expected,
                        actual));
  endtask

  task automatic compare_data(input mini16_fabric_pkg::data_t actual, expected,
                              input string what);
    if (actual !== expected)
    begin
      report_mismatch(what, $sformatf("%h", expected), $sformatf("%h", actual));
    end
  endtask

  task automatic compare_pe_wr(input mini16_fabric_pkg::master_wr_t actual, expected,
                               input string what);
    if (actual !== expected)
    begin
      report_mismatch(what, $sformatf("%h", expected), $sformatf("%h", actual));
    end
  endtask

  task automatic compare_led(input mini16_fabric_pkg::led_t actual, expected, input string what);
    if (actual !== expected)
    begin
      report_mismatch(what, $sformatf("%h", expected), $sformatf("%h", actual));
    end
  endtask

  task automatic compare_flag(input logic actual, expected, input string what);
    if (actual !== expected)
    begin
      report_mismatch(what, $sformatf("%b", expected), $sformatf("%b", actual));
    end
  endtask

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit)
    begin
      abort_run($sformatf("Timeout: the run did not finish within %0d cycles", cycle_limit));
    end
  end

  always @(posedge clk)
  begin
    if (rst)
    begin
      rd_v1 <= 1'b0;
      rd_v2 <= 1'b0;
    end
    else
    begin
      rd_v1 <= rd_issue;
      rd_v2 <= rd_v1;
    end
    rd_e1 <= rd_expect;
    rd_e2 <= rd_e1;
    rd_a1 <= master_raddr;
    rd_a2 <= rd_a1;
  end

  always @(posedge clk)
  begin
    pe_idle <= !master_wr.we;
  end

  always @(negedge clk)
  begin
    if (rd_v2)
    begin
      compare_data(master_rdata, rd_e2, $sformatf("master_rdata for address %h", rd_a2));
    end
    if (pe_idle)
    begin
      compare_flag(pe_wr.we, 1'b0, "pe_wr.we one cycle after a cycle without a master write");
    end
  end

  // Drives a one-cycle strobe and checks it on pe_wr in the next cycle
  task automatic master_write(input mini16_fabric_pkg::w_addr_t addr,
                              input mini16_fabric_pkg::data_t data);
    mini16_fabric_pkg::master_wr_t expect_wr;
    expect_wr.addr = addr;
    expect_wr.data = data;
    expect_wr.we   = 1'b1;
    master_wr <= expect_wr;
    @(posedge clk);
    master_wr.we <= 1'b0;
    @(negedge clk);
    compare_pe_wr(pe_wr, expect_wr, "pe_wr one cycle after the write");
  endtask

  task automatic harvest_write(input mini16_fabric_pkg::f_addr_t addr,
                               input mini16_fabric_pkg::data_t data);
    harvest_wr <= '{addr: addr, data: data, we: 1'b1};
    @(posedge clk);
    harvest_wr.we <= 1'b0;
  endtask

  initial
  begin
    logic [31:0] op;
    logic [31:0] addr_w;
    logic [31:0] data_w;
    logic [31:0] expect_w;
    rst          <= 1'b1;
    master_wr    <= '0;
    master_raddr <= '0;
    harvest_wr   <= '0;
    rd_issue     <= 1'b0;
    rd_expect    <= '0;
    $readmemh("testbench/fabric_cases.txt", case_mem);
    n_cases = 0;
    while (n_cases < MAX_CASES && case_mem[4*n_cases] !== OP_END)
    begin
      n_cases++;
    end
    if (n_cases == 0 || n_cases == MAX_CASES)
    begin
      abort_run("The case file is missing or has no end marker");
    end
    // Two cycles per case at most plus reset and pipeline drain
    cycle_limit = 4 * n_cases + 50;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < n_cases; i++)
    begin
      op       = case_mem[4*i];
      addr_w   = case_mem[4*i+1];
      data_w   = case_mem[4*i+2];
      expect_w = case_mem[4*i+3];
      @(posedge clk);
      rd_issue <= (op == OP_READ);
      case (op)
        OP_MASTER_WR:
        begin
          master_write(addr_w[$bits(mini16_fabric_pkg::w_addr_t)-1:0], data_w);
        end
        OP_HARVEST_WR:
        begin
          harvest_write(addr_w[$bits(mini16_fabric_pkg::f_addr_t)-1:0], data_w);
        end
        OP_READ:
        begin
          master_raddr <= addr_w[$bits(mini16_fabric_pkg::r_addr_t)-1:0];
          rd_expect    <= expect_w;
        end
        OP_LED:
        begin
          @(negedge clk);
          compare_led(led, expect_w[15:0], "led");
        end
        OP_SOFT_RESET:
        begin
          @(negedge clk);
          compare_flag(pe_soft_reset, expect_w[0], "pe_soft_reset");
        end
        default:
        begin
          abort_run($sformatf("Unknown operation %h in case %0d", op, i));
        end
      endcase
    end
    @(posedge clk);
    rd_issue <= 1'b0;
    repeat (3) @(posedge clk);
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/bus_decode.sv
/* Write strobes are single-cycle and always accepted; there is no back-pressure.
   Harvester writes to the VRAM bank are dropped here. */
`timescale 1ns/1ps
`default_nettype none

module bus_decode (
  input  wire                              clk,
  input  wire                              rst,
  input  wire mini16_fabric_pkg::master_wr_t  master_wr,
  input  wire mini16_fabric_pkg::harvest_wr_t harvest_wr,
  output wire mini16_fabric_pkg::ram_wr_t     mem_d_wr,
  output wire mini16_fabric_pkg::ram_wr_t     io_wr,
  output wire mini16_fabric_pkg::ram_wr_t     s2m_wr,
  output wire mini16_fabric_pkg::master_wr_t  pe_wr
);

  logic [mini16_fabric_pkg::CORE_BITS-1:0] w_bank;
  logic                                    f_bank;

  mini16_fabric_pkg::master_wr_t mw_q;
  logic                          mem_d_we_q;
  logic                          io_we_q;

  mini16_fabric_pkg::f_addr_t hw_addr_q;
  mini16_fabric_pkg::data_t   hw_data_q;
  logic                       s2m_we_q;

  assign w_bank = master_wr.addr[mini16_fabric_pkg::DEPTH_B_M_W +: mini16_fabric_pkg::CORE_BITS];
  assign f_bank = harvest_wr.addr[mini16_fabric_pkg::DEPTH_B_F];

  // Master port, also the delayed PE write bus
  always_ff @(posedge clk)
  begin
    mw_q <= master_wr;
    if (rst)
    begin
      mw_q.we <= 1'b0;
    end
  end

  // Local strobes, PE and broadcast banks raise none
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mem_d_we_q <= 1'b0;
      io_we_q    <= 1'b0;
    end
    else
    begin
      mem_d_we_q <= master_wr.we && (w_bank == mini16_fabric_pkg::W_BANK_MEM_D);
      io_we_q    <= master_wr.we && (w_bank == mini16_fabric_pkg::W_BANK_IO_REG);
    end
  end

  // Harvester port
  always_ff @(posedge clk)
  begin
    hw_addr_q <= harvest_wr.addr;
    hw_data_q <= harvest_wr.data;
    if (rst)
    begin
      s2m_we_q <= 1'b0;
    end
    else
    begin
      s2m_we_q <= harvest_wr.we && (f_bank == mini16_fabric_pkg::F_BANK_S2M);
    end
  end

  assign mem_d_wr.addr = mw_q.addr[mini16_fabric_pkg::DEPTH_M_D-1:0];
  assign mem_d_wr.data = mw_q.data;
  assign mem_d_wr.we   = mem_d_we_q;

  // I/O file only looks at the low index bits
  assign io_wr.addr = mw_q.addr[mini16_fabric_pkg::DEPTH_M_D-1:0];
  assign io_wr.data = mw_q.data;
  assign io_wr.we   = io_we_q;

  assign s2m_wr.addr = hw_addr_q[mini16_fabric_pkg::DEPTH_M_D-1:0];
  assign s2m_wr.data = hw_data_q;
  assign s2m_wr.we   = s2m_we_q;

  assign pe_wr = mw_q;

endmodule

`default_nettype wire

//--- verilog/io_reg_file.sv
/* Write-only control registers with readback; reads return what was written.
   All registers clear on reset so led and pe_soft_reset start at 0. */
`timescale 1ns/1ps
`default_nettype none

module io_reg_file (
  input  wire                              clk,
  input  wire                              rst,
  input  wire mini16_fabric_pkg::ram_wr_t  io_wr,
  input  wire mini16_fabric_pkg::io_idx_t  raddr,
  output mini16_fabric_pkg::data_t         rdata,
  output wire mini16_fabric_pkg::led_t     led,
  output wire                              pe_soft_reset
);

  localparam int NUM_REGS = 1 << mini16_fabric_pkg::DEPTH_IO_REG;

  mini16_fabric_pkg::data_t   regs [0:NUM_REGS-1];
  mini16_fabric_pkg::io_idx_t w_idx;

  assign w_idx = io_wr.addr[mini16_fabric_pkg::DEPTH_IO_REG-1:0];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (io_wr.we)
    begin
      regs[w_idx] <= io_wr.data;
    end
  end

  // Readback lines up with the RAM read latency
  always_ff @(posedge clk)
  begin
    rdata <= regs[raddr];
  end

  assign led           = regs[mini16_fabric_pkg::IO_REG_W_LED][15:0];
  assign pe_soft_reset = regs[mini16_fabric_pkg::IO_REG_W_RESET_PE][0];

endmodule

`default_nettype wire

//--- verilog/mini16_fabric.sv
/* Master-side fabric: write decode, data memory, I/O registers, s2m RAM and read mux.
   Reads have two cycles of latency, writes land one cycle after the strobe. */
`timescale 1ns/1ps
`default_nettype none

module mini16_fabric (
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire mini16_fabric_pkg::master_wr_t   master_wr,
  input  wire mini16_fabric_pkg::r_addr_t      master_raddr,
  input  wire mini16_fabric_pkg::harvest_wr_t  harvest_wr,
  output wire mini16_fabric_pkg::data_t        master_rdata,
  output wire mini16_fabric_pkg::master_wr_t   pe_wr,
  output wire mini16_fabric_pkg::led_t         led,
  output wire                                  pe_soft_reset
);

  mini16_fabric_pkg::ram_wr_t mem_d_wr;
  mini16_fabric_pkg::ram_wr_t io_wr;
  mini16_fabric_pkg::ram_wr_t s2m_wr;

  mini16_fabric_pkg::data_t mem_d_rdata;
  mini16_fabric_pkg::data_t io_rdata;
  mini16_fabric_pkg::data_t s2m_rdata;

  bus_decode u_bus_decode (
    .clk        (clk),
    .rst        (rst),
    .master_wr  (master_wr),
    .harvest_wr (harvest_wr),
    .mem_d_wr   (mem_d_wr),
    .io_wr      (io_wr),
    .s2m_wr     (s2m_wr),
    .pe_wr      (pe_wr)
  );

  // Master data memory
  shared_ram #(
    .DATA_WIDTH (mini16_fabric_pkg::WIDTH_D),
    .ADDR_WIDTH (mini16_fabric_pkg::DEPTH_M_D)
  ) u_mem_d (
    .clk   (clk),
    .wr    (mem_d_wr),
    .raddr (master_raddr[mini16_fabric_pkg::DEPTH_M_D-1:0]),
    .rdata (mem_d_rdata)
  );

  // Slave-to-master RAM, written by the harvester
  shared_ram #(
    .DATA_WIDTH (mini16_fabric_pkg::WIDTH_D),
    .ADDR_WIDTH (mini16_fabric_pkg::DEPTH_S2M)
  ) u_s2m (
    .clk   (clk),
    .wr    (s2m_wr),
    .raddr (master_raddr[mini16_fabric_pkg::DEPTH_S2M-1:0]),
    .rdata (s2m_rdata)
  );

  io_reg_file u_io_reg_file (
    .clk           (clk),
    .rst           (rst),
    .io_wr         (io_wr),
    .raddr         (master_raddr[mini16_fabric_pkg::DEPTH_IO_REG-1:0]),
    .rdata         (io_rdata),
    .led           (led),
    .pe_soft_reset (pe_soft_reset)
  );

  read_select u_read_select (
    .clk         (clk),
    .raddr       (master_raddr),
    .mem_d_rdata (mem_d_rdata),
    .io_rdata    (io_rdata),
    .s2m_rdata   (s2m_rdata),
    .rdata       (master_rdata)
  );

endmodule

`default_nettype wire

//--- verilog/mini16_fabric_pkg.sv
/* Address layouts follow the master and harvester buses: bank field on top, base field below.
   ram_wr_t carries an 11-bit address and narrower users take its low bits. */
`default_nettype none

package mini16_fabric_pkg;

  // Widths
  localparam int WIDTH_D      = 32;
  localparam int DEPTH_M_D    = 11;
  localparam int DEPTH_S2M    = 9;
  localparam int DEPTH_IO_REG = 5;
  localparam int CORE_BITS    = 6;
  localparam int DEPTH_B_M_W  = 12;
  localparam int DEPTH_B_M_R  = 11;
  localparam int DEPTH_B_F    = 17;

  typedef logic [WIDTH_D-1:0]                 data_t;
  typedef logic [CORE_BITS+DEPTH_B_M_W-1:0]   w_addr_t;
  typedef logic [1:0]                         r_bank_t;
  typedef logic [$bits(r_bank_t)+DEPTH_B_M_R-1:0] r_addr_t;
  typedef logic [DEPTH_B_F:0]                 f_addr_t;
  typedef logic [DEPTH_IO_REG-1:0]            io_idx_t;
  typedef logic [15:0]                        led_t;

  // Master write banks, PE banks sit between I/O and broadcast
  localparam logic [CORE_BITS-1:0] W_BANK_MEM_D  = 6'd0;
  localparam logic [CORE_BITS-1:0] W_BANK_IO_REG = 6'd1;
  localparam logic [CORE_BITS-1:0] W_BANK_BC     = 6'd63;

  // Master read banks, 2 and 3 fall through to s2m
  localparam r_bank_t R_BANK_MEM_D  = 2'd0;
  localparam r_bank_t R_BANK_IO_REG = 2'd1;

  // Harvester banks
  localparam logic F_BANK_S2M  = 1'b0;
  localparam logic F_BANK_VRAM = 1'b1;

  // I/O write register indices
  localparam io_idx_t IO_REG_W_RESET_PE = 5'd0;
  localparam io_idx_t IO_REG_W_LED      = 5'd1;

  typedef struct packed {
    w_addr_t addr;
    data_t   data;
    logic    we;
  } master_wr_t;

  typedef struct packed {
    f_addr_t addr;
    data_t   data;
    logic    we;
  } harvest_wr_t;

  typedef struct packed {
    logic [DEPTH_M_D-1:0] addr;
    data_t                data;
    logic                 we;
  } ram_wr_t;

endpackage

`default_nettype wire

//--- verilog/read_select.sv
/* Sources must return data one cycle after the address; output adds one more.
   Banks 2 and 3 both read s2m. */
`timescale 1ns/1ps
`default_nettype none

module read_select (
  input  wire                             clk,
  input  wire mini16_fabric_pkg::r_addr_t raddr,
  input  wire mini16_fabric_pkg::data_t   mem_d_rdata,
  input  wire mini16_fabric_pkg::data_t   io_rdata,
  input  wire mini16_fabric_pkg::data_t   s2m_rdata,
  output mini16_fabric_pkg::data_t        rdata
);

  mini16_fabric_pkg::r_bank_t bank;
  mini16_fabric_pkg::r_bank_t bank_q;

  assign bank = raddr[mini16_fabric_pkg::DEPTH_B_M_R +: $bits(mini16_fabric_pkg::r_bank_t)];

  // Bank follows the address through the source read stage
  always_ff @(posedge clk)
  begin
    bank_q <= bank;
  end

  always_ff @(posedge clk)
  begin
    case (bank_q)
      mini16_fabric_pkg::R_BANK_MEM_D:
      begin
        rdata <= mem_d_rdata;
      end
      mini16_fabric_pkg::R_BANK_IO_REG:
      begin
        rdata <= io_rdata;
      end
      default:
      begin
        rdata <= s2m_rdata;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/shared_ram.sv
/* DATA_WIDTH up to 32 and ADDR_WIDTH up to 11, the widths carried by ram_wr_t.
   Contents are undefined until written. */
`timescale 1ns/1ps
`default_nettype none

module shared_ram #(
  parameter int DATA_WIDTH = 32,
  parameter int ADDR_WIDTH = 11
) (
  input  wire                          clk,
  input  wire mini16_fabric_pkg::ram_wr_t wr,
  input  wire [ADDR_WIDTH-1:0]         raddr,
  output logic [DATA_WIDTH-1:0]        rdata
);

  logic [DATA_WIDTH-1:0] mem [0:(1 << ADDR_WIDTH)-1];

  always_ff @(posedge clk)
  begin
    if (wr.we)
    begin
      mem[wr.addr[ADDR_WIDTH-1:0]] <= wr.data[DATA_WIDTH-1:0];
    end
    // Registered read, one cycle after the address
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire
